/* logic/capture_pkg.sv */
package capture_pkg;

    // Sample and word widths.
    localparam int sample_w = 24;
    localparam int seq_w    = 8;
    localparam int word_w   = 32;

    // FIFO sizing.
    localparam int fifo_depth = 16;
    localparam int ptr_w      = 4;   // Log2 of fifo_depth.
    localparam int level_w    = 5;   // Holds 0 to fifo_depth.

    // Saturating drop counter.
    localparam int drop_w = 16;

    // AXI read side.
    localparam int addr_w = 12;
    localparam int id_w   = 4;

    // Address map.
    localparam logic [addr_w-1:0] data_addr   = 12'h000;
    localparam logic [addr_w-1:0] status_addr = 12'h004;

    // Response codes.
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Status word is the drop count in bits 31..16 and the level in bits 4..0.

endpackage

/* logic/fifo_read_if.sv */
`timescale 1ns/1ps

interface fifo_read_if;
    import capture_pkg::*;

    logic               pop;         // From the AXI port, only while empty is low.
    logic [word_w-1:0]  rdata;       // Head word, first-word fall-through.
    logic               empty;
    logic [level_w-1:0] level;
    logic [drop_w-1:0]  drop_count;  // Driven by the packer.

    // FIFO and packer share this side, each drives its own signals.
    modport fifo_side (
        input  pop,
        output rdata,
        output empty,
        output level,
        output drop_count
    );

    modport port_side (
        output pop,
        input  rdata,
        input  empty,
        input  level,
        input  drop_count
    );

endinterface

/* logic/sample_packer.sv */
`timescale 1ns/1ps

module sample_packer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clear,
    input  logic [capture_pkg::sample_w-1:0] sample,
    input  logic                             sample_valid,
    input  logic                             full,
    output logic                             push,
    output logic [capture_pkg::word_w-1:0]   wdata,
    fifo_read_if.fifo_side                   rd
);
    import capture_pkg::*;

    logic [seq_w-1:0]  seq;
    logic              pending;   // A tagged word waits in wdata.
    logic [drop_w-1:0] drops;

    // Tag the sample with its sequence number.
    // The sequence advances on every sample, stored or dropped.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq     <= '0;
            pending <= 1'b0;
        end else if (clear) begin
            seq     <= '0;
            pending <= 1'b0;   // Sample arriving with clear is discarded.
        end else begin
            pending <= sample_valid;
            if (sample_valid) begin
                seq <= seq + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            wdata <= {seq, sample};
        end
    end

    // The pending word is pushed one edge later, unless the FIFO is full.
    assign push = pending && !full;

    // Lost words.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drops <= '0;
        end else if (clear) begin
            drops <= '0;
        end else if (pending && full && drops != '1) begin
            drops <= drops + 1'b1;   // Saturates at all ones.
        end
    end

    assign rd.drop_count = drops;

endmodule

/* logic/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clear,
    input  logic                           push,
    input  logic [capture_pkg::word_w-1:0] wdata,
    output logic                           full,
    fifo_read_if.fifo_side                 rd
);
    import capture_pkg::*;

    logic [word_w-1:0]  mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [level_w-1:0] count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push && !full;
    assign do_pop  = rd.pop && !rd.empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Pointers wrap at the depth. Clear beats push and pop.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Push with pop keeps the level.
            endcase
        end
    end

    assign full     = (count == level_w'(fifo_depth));
    assign rd.empty = (count == '0);
    assign rd.level = count;
    assign rd.rdata = mem[rd_ptr];   // Head word, no read latency.

endmodule

/* logic/axi_read_port.sv */
`timescale 1ns/1ps

module axi_read_port (
    input  logic                           clk,
    input  logic                           rst_n,
    // AR channel.
    input  logic [capture_pkg::id_w-1:0]   arid,
    input  logic [capture_pkg::addr_w-1:0] araddr,
    input  logic [7:0]                     arlen,
    input  logic                           arvalid,
    output logic                           arready,
    // R channel.
    output logic [capture_pkg::id_w-1:0]   rid,
    output logic [capture_pkg::word_w-1:0] rdata,
    output logic [1:0]                     rresp,
    output logic                           rlast,
    output logic                           rvalid,
    input  logic                           rready,
    fifo_read_if.port_side                 rd
);
    import capture_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_beat
    } state_t;

    typedef enum logic [1:0] {
        cls_data,
        cls_status,
        cls_error
    } addr_cls_t;

    state_t            state;
    addr_cls_t         ar_cls;
    addr_cls_t         cls_r;
    logic [7:0]        beat_cnt;   // Beats left after the current one.
    logic [word_w-1:0] status_word;
    logic              beat_done;

    // Address decode.
    always_comb begin
        if (araddr == data_addr) begin
            ar_cls = cls_data;
        end else if (araddr == status_addr) begin
            ar_cls = cls_status;
        end else begin
            ar_cls = cls_error;
        end
    end

    always_comb begin
        status_word                           = '0;
        status_word[level_w-1:0]              = rd.level;
        status_word[word_w-1:word_w-drop_w]   = rd.drop_count;
    end

    assign beat_done = (state == st_beat) && rvalid && rready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            beat_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (arvalid) begin
                        state    <= st_wait;
                        beat_cnt <= arlen;
                    end
                end
                st_wait: begin
                    // A data beat waits for a word in the FIFO.
                    if (cls_r != cls_data || !rd.empty) begin
                        state  <= st_beat;
                        rvalid <= 1'b1;
                        rlast  <= (beat_cnt == '0);
                    end
                end
                st_beat: begin
                    if (beat_done) begin
                        rvalid <= 1'b0;
                        if (rlast) begin
                            state <= st_idle;
                            rlast <= 1'b0;
                        end else begin
                            state    <= st_wait;
                            beat_cnt <= beat_cnt - 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Burst payload. The status word is sampled as its beat is presented.
    always_ff @(posedge clk) begin
        if (state == st_idle && arvalid) begin
            rid   <= arid;
            cls_r <= ar_cls;
        end
        if (state == st_wait) begin
            case (cls_r)
                cls_data:   rdata <= rd.rdata;
                cls_status: rdata <= status_word;
                default:    rdata <= '0;
            endcase
        end
    end

    assign arready = (state == st_idle);
    assign rresp   = (cls_r == cls_error) ? resp_slverr : resp_okay;

    // Pop the head on the handshake of a data beat.
    assign rd.pop = beat_done && (cls_r == cls_data);

endmodule

/* logic/stream_capture_top.sv */
`timescale 1ns/1ps

module stream_capture_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clear,
    // Sample stream, no back-pressure.
    input  logic [capture_pkg::sample_w-1:0] sample,
    input  logic                             sample_valid,
    // AXI4 read address.
    input  logic [capture_pkg::id_w-1:0]     arid,
    input  logic [capture_pkg::addr_w-1:0]   araddr,
    input  logic [7:0]                       arlen,
    input  logic                             arvalid,
    output logic                             arready,
    // AXI4 read data.
    output logic [capture_pkg::id_w-1:0]     rid,
    output logic [capture_pkg::word_w-1:0]   rdata,
    output logic [1:0]                       rresp,
    output logic                             rlast,
    output logic                             rvalid,
    input  logic                             rready
);
    import capture_pkg::*;

    logic              push;
    logic [word_w-1:0] wdata;
    logic              full;

    fifo_read_if rd_bus ();

    sample_packer u_packer (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .sample       (sample),
        .sample_valid (sample_valid),
        .full         (full),
        .push         (push),
        .wdata        (wdata),
        .rd           (rd_bus.fifo_side)
    );

    word_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (clear),
        .push  (push),
        .wdata (wdata),
        .full  (full),
        .rd    (rd_bus.fifo_side)
    );

    axi_read_port u_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd      (rd_bus.port_side)
    );

endmodule

/* test/capture_asserts.sv */
`timescale 1ns/1ps

module capture_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           arready,
    input logic                           rvalid,
    input logic                           rready,
    input logic [capture_pkg::word_w-1:0] rdata,
    input logic                           pop,
    input logic                           empty
);

    int fail_count = 0;   // Read by the testbench at the end.

    // A stalled beat keeps its payload.
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else begin
            fail_count++;
            $error("R beat changed while rready was low");
        end

    // No new address while a beat is presented.
    ar_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> !arready)
        else begin
            fail_count++;
            $error("arready high while rvalid was high");
        end

    pop_safe: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty))
        else begin
            fail_count++;
            $error("FIFO popped while empty");
        end

endmodule

bind axi_read_port capture_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .pop     (rd.pop),
    .empty   (rd.empty)
);

/* test/capture_tb.sv */
`timescale 1ns/1ps

module capture_tb;
    import capture_pkg::*;

    localparam int clk_period   = 4;
    localparam int watchdog_cyc = 4000;
    localparam int wait_limit   = 200;   // Cycles allowed for one handshake.

    logic                clk;
    logic                rst_n;
    logic                clear;
    logic [sample_w-1:0] sample;
    logic                sample_valid;
    logic [id_w-1:0]     arid;
    logic [addr_w-1:0]   araddr;
    logic [7:0]          arlen;
    logic                arvalid;
    logic                arready;
    logic [id_w-1:0]     rid;
    logic [word_w-1:0]   rdata;
    logic [1:0]          rresp;
    logic                rlast;
    logic                rvalid;
    logic                rready;

    logic [31:0]         rng;
    int                  n_checks;
    int                  n_errors;
    int                  n_assert_fails;
    logic [word_w-1:0]   model_q[$];   // Words the FIFO should hold.
    logic [seq_w-1:0]    model_seq;
    logic [drop_w-1:0]   model_drops;
    logic [word_w-1:0]   beat_data[$];
    logic [1:0]          beat_resp[$];

    stream_capture_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .sample       (sample),
        .sample_valid (sample_valid),
        .arid         (arid),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .arready      (arready),
        .rid          (rid),
        .rdata        (rdata),
        .rresp        (rresp),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(clk_period * watchdog_cyc);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cyc);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Drop count in 31..16, level in the low bits, zeros elsewhere.
    function automatic logic [31:0] status_of(input int level, input logic [drop_w-1:0] drops);
        logic [31:0] w;
        w                 = '0;
        w[level_w-1:0]    = level[level_w-1:0];
        w[31:32-drop_w]   = drops;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_problem(input string what);
        n_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic model_sample(input logic [sample_w-1:0] s);
        if (model_q.size() < fifo_depth) begin
            model_q.push_back({model_seq, s});
        end else if (model_drops != '1) begin
            model_drops++;
        end
        model_seq++;   // Advances on dropped samples too.
    endtask

    task automatic pulse_clear();
        @(negedge clk);
        clear = 1'b1;
        model_q.delete();
        model_seq   = '0;
        model_drops = '0;
        @(negedge clk);
        clear = 1'b0;
    endtask

    task automatic drive_samples(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            rng          = xorshift(rng);
            sample       = rng[sample_w-1:0];
            sample_valid = 1'b1;
            model_sample(rng[sample_w-1:0]);
        end
        @(negedge clk);
        sample_valid = 1'b0;
        @(negedge clk);   // Last word lands in the FIFO.
    endtask

    task automatic request_read(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                                input logic [7:0] len);
        int waited;
        waited = 0;
        @(negedge clk);
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arvalid = 1'b1;
        while (!arready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!arready) begin
            report_problem("read address was never accepted");
        end
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    // Random rready, low for stall_pct percent of the cycles.
    task automatic collect_beats(input int n, input logic [id_w-1:0] id, input int stall_pct);
        int waited;
        beat_data.delete();
        beat_resp.delete();
        waited = 0;
        while (beat_data.size() < n && waited < wait_limit) begin
            @(negedge clk);
            rng    = xorshift(rng);
            rready = (rng % 100) >= stall_pct;
            if (rvalid && rready) begin   // Handshake at the next rising edge.
                beat_data.push_back(rdata);
                beat_resp.push_back(rresp);
                check_value("rid", 32'(rid), 32'(id));
                check_value("rlast", 32'(rlast), 32'(beat_data.size() == n));
                waited = 0;
            end else begin
                waited++;
            end
        end
        if (beat_data.size() < n) begin
            report_problem("read burst stopped before its last beat");
        end
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic read_burst(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                              input logic [7:0] len, input int stall_pct);
        request_read(id, addr, len);
        collect_beats(int'(len) + 1, id, stall_pct);
    endtask

    task automatic compare_data_beats();
        int i;
        for (i = 0; i < beat_data.size(); i++) begin
            if (model_q.size() == 0) begin
                report_problem("data beat returned with no word expected");
            end else begin
                check_value("rdata", beat_data[i], model_q.pop_front());
            end
            check_value("rresp", 32'(beat_resp[i]), 32'(resp_okay));
        end
    endtask

    task automatic check_status();
        read_burst(4'h1, status_addr, 8'd0, 0);
        if (beat_data.size() == 1) begin
            check_value("status rdata", beat_data[0], status_of(model_q.size(), model_drops));
            check_value("status rresp", 32'(beat_resp[0]), 32'(resp_okay));
        end
    endtask

    task automatic test_reset_state();
        check_value("arready", 32'(arready), 32'd1);
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_status();
    endtask

    task automatic test_ordered_capture();
        drive_samples(8);
        read_burst(4'h5, data_addr, 8'd7, 0);
        compare_data_beats();
    endtask

    task automatic test_overflow();
        pulse_clear();
        drive_samples(20);
        read_burst(4'h3, status_addr, 8'd0, 0);
        if (beat_data.size() == 1) begin
            check_value("status rdata", beat_data[0], 32'h0004_0010);   // 4 drops, level 16.
        end
        read_burst(4'h3, data_addr, 8'd15, 0);
        compare_data_beats();
        drive_samples(1);
        read_burst(4'h3, data_addr, 8'd0, 0);
        if (beat_data.size() == 1) begin
            check_value("rdata seq", 32'(beat_data[0][31:24]), 32'd20);
        end
        compare_data_beats();
    endtask

    task automatic test_backpressure();
        int level_before;
        drive_samples(10);
        check_status();
        level_before = model_q.size();
        read_burst(4'h9, data_addr, 8'd5, 60);
        compare_data_beats();
        read_burst(4'h9, status_addr, 8'd0, 0);
        if (beat_data.size() == 1) begin
            check_value("status level", 32'(beat_data[0][level_w-1:0]), 32'(level_before - 6));
        end
    endtask

    task automatic test_clear_wait();
        int stray;
        int i;
        stray = 0;
        pulse_clear();
        check_status();
        request_read(4'h2, data_addr, 8'd1);
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            if (rvalid) begin
                stray++;
            end
        end
        if (stray != 0) begin
            report_problem("data beat presented while the FIFO was empty");
        end
        drive_samples(2);
        collect_beats(2, 4'h2, 0);
        compare_data_beats();
    endtask

    task automatic test_error_response();
        int i;
        drive_samples(3);
        read_burst(4'h7, 12'h010, 8'd3, 0);
        for (i = 0; i < beat_data.size(); i++) begin
            check_value("error rdata", beat_data[i], 32'h0);
            check_value("error rresp", 32'(beat_resp[i]), 32'(resp_slverr));
        end
        check_status();   // Level still 3.
        read_burst(4'h7, data_addr, 8'd2, 0);
        compare_data_beats();
    endtask

    initial begin
        rst_n        = 1'b0;
        clear        = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        arid         = '0;
        araddr       = '0;
        arlen        = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        rng          = 32'd13;
        n_checks     = 0;
        n_errors     = 0;
        model_seq    = '0;
        model_drops  = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_ordered_capture();
        test_overflow();
        test_backpressure();
        test_clear_wait();
        test_error_response();

        n_assert_fails = dut.u_port.u_asserts.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, n_assert_fails);
        if (n_errors == 0 && n_assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
logic/capture_pkg.sv
logic/fifo_read_if.sv
logic/sample_packer.sv
logic/word_fifo.sv
logic/axi_read_port.sv
logic/stream_capture_top.sv
test/capture_asserts.sv
test/capture_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module capture_tb -f all.f -o capture_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/capture_sim +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
